// ==== rtl/eth_tx_pkg.sv ====
package eth_tx_pkg;

    // Byte stream
    localparam int byte_width = 8;

    // Preamble and SFD
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hD5;
    localparam int preamble_len          = 8;    // 7 x 55 plus SFD

    // Frame sizing, FCS excluded
    localparam int min_frame_bytes = 60;
    localparam int max_frame_bytes = 1514;       // Source must stay below this
    localparam int fcs_len         = 4;

    // IEEE 802.3 CRC-32, reflected form
    localparam logic [31:0] crc_poly      = 32'hEDB88320;
    localparam logic [31:0] crc_init      = 32'hFFFFFFFF;
    localparam logic [31:0] crc_final_xor = 32'hFFFFFFFF;

    // Register block
    localparam int gap_width                 = 8;
    localparam logic [7:0] default_gap_len   = 8'd12;
    localparam int count_width               = 16;
    localparam int frame_len_width           = 11;   // Enough for 1514
    localparam int wb_data_width             = 32;
    localparam int wb_addr_width             = 2;
    localparam int ctrl_enable_bit           = 0;    // tx_enable position in ctrl

    // Framer FSM
    typedef enum logic [2:0] {
        state_idle,
        state_preamble,
        state_payload,
        state_pad,
        state_fcs,
        state_gap
    } framer_state_e;

    // Register word addresses
    typedef enum logic [wb_addr_width-1:0] {
        addr_ctrl        = 2'd0,
        addr_gap         = 2'd1,
        addr_frame_count = 2'd2,   // Read only
        addr_reserved    = 2'd3    // Reads zero
    } csr_addr_e;

endpackage

// ==== rtl/eth_crc32.sv ====
module eth_crc32 (
    input  logic                             logic_clk,
    input  logic                             logic_rst,
    input  logic                             crc_clear,   // Back to init next cycle
    input  logic                             crc_valid,   // Fold crc_byte in
    input  logic [eth_tx_pkg::byte_width-1:0] crc_byte,
    output logic [31:0]                      crc_value    // Already final-XORed
);

    logic [31:0] crc_q;      // Running remainder
    logic [31:0] crc_next;   // Remainder after one more byte

    // One byte, LSB first, eight shift steps
    always_comb begin
        crc_next = crc_q ^ 32'(crc_byte);
        for (int i = 0; i < eth_tx_pkg::byte_width; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ eth_tx_pkg::crc_poly;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst || crc_clear) begin
            crc_q <= eth_tx_pkg::crc_init;   // Clear wins over a valid byte
        end else if (crc_valid) begin
            crc_q <= crc_next;
        end
    end

    // Complemented remainder is the FCS
    assign crc_value = crc_q ^ eth_tx_pkg::crc_final_xor;

endmodule

// ==== rtl/eth_tx_framer.sv ====
module eth_tx_framer (
    input  logic                                logic_clk,
    input  logic                                logic_rst,
    // Source stream
    input  logic [eth_tx_pkg::byte_width-1:0]   data,
    input  logic                                data_valid,
    input  logic                                data_last,
    output logic                                data_ready,
    // PHY side without back-pressure
    output logic [eth_tx_pkg::byte_width-1:0]   tx_data,
    output logic                                tx_valid,
    // Register block
    input  logic                                tx_enable,
    input  logic [eth_tx_pkg::gap_width-1:0]    gap_len,
    output logic                                frame_done,
    // CRC engine
    output logic                                crc_clear,
    output logic                                crc_valid,
    output logic [eth_tx_pkg::byte_width-1:0]   crc_byte,
    input  logic [31:0]                         crc_value
);

    eth_tx_pkg::framer_state_e state;

    logic [eth_tx_pkg::frame_len_width-1:0] byte_cnt;   // Data plus pad bytes sent
    logic [2:0]                             idx;        // Preamble or FCS byte index
    logic [eth_tx_pkg::gap_width-1:0]       gap_cnt;    // Idle cycles spent in gap

    logic xfer;       // Byte accepted from source
    logic last_pre;   // SFD goes out next
    logic last_fcs;   // Final FCS byte goes out next
    logic [eth_tx_pkg::byte_width-1:0] fcs_byte;

    assign xfer     = data_valid && data_ready;
    assign last_pre = (idx == 3'(eth_tx_pkg::preamble_len - 1));
    assign last_fcs = (idx == 3'(eth_tx_pkg::fcs_len - 1));

    // FCS leaves LSB first
    assign fcs_byte = crc_value[idx[1:0]*eth_tx_pkg::byte_width +: eth_tx_pkg::byte_width];

    // CRC sees each content byte on the edge it reaches tx_data
    assign crc_valid = xfer || (state == eth_tx_pkg::state_pad);
    assign crc_byte  = (state == eth_tx_pkg::state_payload) ? data : '0;   // Pad is zero
    assign crc_clear = (state == eth_tx_pkg::state_fcs) && last_fcs;       // Ready for next frame

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            state      <= eth_tx_pkg::state_idle;
            tx_valid   <= 1'b0;
            data_ready <= 1'b0;
            frame_done <= 1'b0;
            idx        <= '0;
            byte_cnt   <= '0;
            gap_cnt    <= '0;
        end else begin
            frame_done <= 1'b0;   // Single-cycle pulse
            case (state)
                eth_tx_pkg::state_idle: begin
                    tx_valid <= 1'b0;
                    byte_cnt <= '0;
                    idx      <= 3'd1;   // Byte 0 leaves on the start edge
                    // Enable sampled here and never mid-frame
                    if (tx_enable && data_valid) begin
                        tx_valid <= 1'b1;
                        state    <= eth_tx_pkg::state_preamble;
                    end
                end

                eth_tx_pkg::state_preamble: begin
                    tx_valid <= 1'b1;
                    if (last_pre) begin
                        idx        <= '0;     // Reused for FCS
                        data_ready <= 1'b1;   // High while SFD is on the line
                        state      <= eth_tx_pkg::state_payload;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end

                eth_tx_pkg::state_payload: begin
                    tx_valid <= xfer;   // No holes while the source keeps valid up
                    if (xfer) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (data_last) begin
                            data_ready <= 1'b0;
                            // Short frame needs zero fill
                            if (byte_cnt < eth_tx_pkg::min_frame_bytes - 1) begin
                                state <= eth_tx_pkg::state_pad;
                            end else begin
                                state <= eth_tx_pkg::state_fcs;
                            end
                        end
                    end
                end

                eth_tx_pkg::state_pad: begin
                    tx_valid <= 1'b1;
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == eth_tx_pkg::min_frame_bytes - 1) begin
                        state <= eth_tx_pkg::state_fcs;   // 60th byte out
                    end
                end

                eth_tx_pkg::state_fcs: begin
                    tx_valid <= 1'b1;
                    idx      <= idx + 1'b1;
                    if (last_fcs) begin
                        frame_done <= 1'b1;   // Lines up with last FCS byte
                        gap_cnt    <= '0;
                        state      <= eth_tx_pkg::state_gap;
                    end
                end

                eth_tx_pkg::state_gap: begin
                    tx_valid <= 1'b0;
                    // gap_len low cycles here and one more in idle
                    if (gap_cnt >= gap_len) begin
                        state <= eth_tx_pkg::state_idle;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end

                default: begin
                    tx_valid   <= 1'b0;
                    data_ready <= 1'b0;
                    state      <= eth_tx_pkg::state_idle;
                end
            endcase
        end
    end

    // Line byte meaningful only while tx_valid is high
    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            tx_data <= '0;
        end else begin
            case (state)
                eth_tx_pkg::state_idle:     tx_data <= eth_tx_pkg::preamble_byte;
                eth_tx_pkg::state_preamble: tx_data <= last_pre ? eth_tx_pkg::sfd_byte
                                                                : eth_tx_pkg::preamble_byte;
                eth_tx_pkg::state_payload:  tx_data <= data;   // One cycle behind acceptance
                eth_tx_pkg::state_fcs:      tx_data <= fcs_byte;
                default:                    tx_data <= '0;     // Pad and gap
            endcase
        end
    end

endmodule

// ==== rtl/eth_tx_csr.sv ====
module eth_tx_csr (
    input  logic                                  logic_clk,
    input  logic                                  logic_rst,
    // Wishbone classic slave
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [eth_tx_pkg::wb_addr_width-1:0]  wb_adr,
    input  logic [eth_tx_pkg::wb_data_width-1:0]  wb_dat_w,
    output logic [eth_tx_pkg::wb_data_width-1:0]  wb_dat_r,
    output logic                                  wb_ack,
    // Framer control
    output logic                                  tx_enable,
    output logic [eth_tx_pkg::gap_width-1:0]      gap_len,
    input  logic                                  frame_done
);

    logic [eth_tx_pkg::count_width-1:0] frame_count;   // Wraps
    logic [eth_tx_pkg::wb_data_width-1:0] rd_mux;
    logic req;   // New access not yet acked

    assign req = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        case (eth_tx_pkg::csr_addr_e'(wb_adr))
            eth_tx_pkg::addr_ctrl:        rd_mux = eth_tx_pkg::wb_data_width'(tx_enable);
            eth_tx_pkg::addr_gap:         rd_mux = eth_tx_pkg::wb_data_width'(gap_len);
            eth_tx_pkg::addr_frame_count: rd_mux = eth_tx_pkg::wb_data_width'(frame_count);
            default:                      rd_mux = '0;   // Reserved
        endcase
    end

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            wb_ack      <= 1'b0;
            tx_enable   <= 1'b0;
            gap_len     <= eth_tx_pkg::default_gap_len;
            frame_count <= '0;
        end else begin
            wb_ack <= req;   // One cycle of latency and one cycle wide
            // Write lands on the ack edge
            if (req && wb_we) begin
                case (eth_tx_pkg::csr_addr_e'(wb_adr))
                    eth_tx_pkg::addr_ctrl: tx_enable <= wb_dat_w[eth_tx_pkg::ctrl_enable_bit];
                    eth_tx_pkg::addr_gap:  gap_len   <= wb_dat_w[eth_tx_pkg::gap_width-1:0];
                    default: ;                                  // Count and reserved ignore writes
                endcase
            end
            if (frame_done) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            wb_dat_r <= '0;
        end else begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

// ==== rtl/eth_tx_top.sv ====
module eth_tx_top (
    input  logic                                  logic_clk,
    input  logic                                  logic_rst,
    // Source stream
    input  logic [eth_tx_pkg::byte_width-1:0]     data,
    input  logic                                  data_valid,
    input  logic                                  data_last,
    output logic                                  data_ready,
    // Wishbone register port
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [eth_tx_pkg::wb_addr_width-1:0]  wb_adr,
    input  logic [eth_tx_pkg::wb_data_width-1:0]  wb_dat_w,
    output logic [eth_tx_pkg::wb_data_width-1:0]  wb_dat_r,
    output logic                                  wb_ack,
    // PHY
    output logic [eth_tx_pkg::byte_width-1:0]     tx_data,
    output logic                                  tx_valid
);

    logic                               tx_enable;
    logic [eth_tx_pkg::gap_width-1:0]   gap_len;
    logic                               frame_done;
    logic                               crc_clear;
    logic                               crc_valid;
    logic [eth_tx_pkg::byte_width-1:0]  crc_byte;
    logic [31:0]                        crc_value;

    eth_tx_framer framer_i (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .data       (data),
        .data_valid (data_valid),
        .data_last  (data_last),
        .data_ready (data_ready),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_enable  (tx_enable),
        .gap_len    (gap_len),
        .frame_done (frame_done),
        .crc_clear  (crc_clear),
        .crc_valid  (crc_valid),
        .crc_byte   (crc_byte),
        .crc_value  (crc_value)
    );

    eth_crc32 crc_i (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .crc_clear (crc_clear),
        .crc_valid (crc_valid),
        .crc_byte  (crc_byte),
        .crc_value (crc_value)
    );

    eth_tx_csr csr_i (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .tx_enable  (tx_enable),
        .gap_len    (gap_len),
        .frame_done (frame_done)
    );

endmodule

// ==== verification/eth_tx_clock_gen.sv ====
module eth_tx_clock_gen (
    output logic logic_clk
);

    // Period of 100, first rising edge at 50
    initial begin
        logic_clk = 1'b0;
        forever #50 logic_clk = ~logic_clk;
    end

endmodule

// ==== verification/eth_tx_assertions.sv ====
module eth_tx_assertions (
    input logic logic_clk,
    input logic logic_rst,
    input logic data_valid,
    input logic data_last,
    input logic data_ready,
    input logic wb_ack,
    input logic tx_valid
);

    int assert_fails = 0;   // Failure tally

    // Source only accepted while a frame is on the line
    ready_in_frame: assert property (@(posedge logic_clk) disable iff (logic_rst)
        data_ready |-> tx_valid)
        else begin
            assert_fails++;
            $error("data_ready high while tx_valid is low");
        end

    // Ack is one cycle wide
    single_ack: assert property (@(posedge logic_clk) disable iff (logic_rst)
        wb_ack |=> !wb_ack)
        else begin
            assert_fails++;
            $error("wb_ack held for two cycles");
        end

    // Last byte closes the source
    last_closes: assert property (@(posedge logic_clk) disable iff (logic_rst)
        data_valid && data_ready && data_last |=> !data_ready)
        else begin
            assert_fails++;
            $error("data_ready still high after the last byte");
        end

    reset_quiet: assert property (@(posedge logic_clk) logic_rst |=> !tx_valid)
        else begin
            assert_fails++;
            $error("tx_valid high right after reset");
        end

endmodule

bind eth_tx_top eth_tx_assertions assertions_i (.*);

// ==== verification/eth_tx_tb.sv ====
module eth_tx_tb;

    typedef logic [7:0] byte_q_t [$];

    localparam int test_gap = 20;                               // Gap for every frame
    localparam int payload_lens [5] = '{20, 100, 30, 64, 45};   // Last three back to back

    logic        logic_clk;
    logic        logic_rst;
    logic [7:0]  data;
    logic        data_valid, data_last, data_ready;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic [7:0]  tx_data;
    logic        tx_valid;

    byte_q_t expected_bytes;      // Every expected line byte in frame order
    int      expected_lens [$];   // tx_valid cycles per frame
    int      errors = 0;
    int      frames_seen = 0;     // Frames ended on the line

    eth_tx_clock_gen clock_gen_i (.logic_clk(logic_clk));

    eth_tx_top eth_tx_top_i (.*);

    // Full line image of one frame with a bitwise CRC
    function automatic byte_q_t expected_frame(byte_q_t payload);
        byte_q_t     frame;
        byte_q_t     body;
        logic [31:0] crc;
        logic        feedback;
        body = payload;
        while (body.size() < eth_tx_pkg::min_frame_bytes)
            body.push_back(8'h00);
        for (int i = 0; i < eth_tx_pkg::preamble_len - 1; i++)
            frame.push_back(eth_tx_pkg::preamble_byte);
        frame.push_back(eth_tx_pkg::sfd_byte);
        crc = eth_tx_pkg::crc_init;
        foreach (body[i]) begin
            frame.push_back(body[i]);
            for (int k = 0; k < 8; k++) begin   // LSB first on the wire
                feedback = crc[0] ^ body[i][k];
                crc      = crc >> 1;
                if (feedback)
                    crc = crc ^ eth_tx_pkg::crc_poly;
            end
        end
        crc = crc ^ eth_tx_pkg::crc_final_xor;
        for (int k = 0; k < eth_tx_pkg::fcs_len; k++)
            frame.push_back(crc[8*k +: 8]);     // Low byte first
        return frame;
    endfunction

    // Classic cycle entered and left on a falling edge
    task automatic wishbone_cycle(input logic we, input logic [1:0] adr,
                                  input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        {wb_cyc, wb_stb, wb_we} = {2'b11, we};
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge logic_clk);
            waited++;
        end while (!wb_ack && waited < 8);
        if (!wb_ack) begin
            errors++;
            $display("No Wishbone ack within 8 cycles at address %0d", adr);
        end
        rdat = wb_dat_r;   // Valid with ack
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    task automatic check_register(input logic [1:0] adr, input logic [31:0] exp);
        logic [31:0] rdat;
        wishbone_cycle(1'b0, adr, 32'd0, rdat);
        if (rdat !== exp) begin
            errors++;
            $display("Error at %0t: wb_dat_r at address %0d expected %08h got %08h",
                     $time, adr, exp, rdat);
        end
    endtask

    // Random payload with valid held from first byte to last
    task automatic send_frame(input int n);
        byte_q_t payload;
        byte_q_t frame;
        logic    accepted;
        for (int i = 0; i < n; i++)
            payload.push_back(8'($urandom));
        frame = expected_frame(payload);
        foreach (frame[i])
            expected_bytes.push_back(frame[i]);
        expected_lens.push_back(frame.size());
        for (int i = 0; i < n; i++) begin
            data       = payload[i];
            data_valid = 1'b1;
            data_last  = (i == n - 1);
            do begin
                accepted = data_ready;   // Taken on the coming rising edge
                @(negedge logic_clk);
            end while (!accepted);
        end
        data_valid = 1'b0;
        data_last  = 1'b0;
    endtask

    task automatic wait_for_frames(input int n);
        int waited;
        waited = 0;
        while (frames_seen < n && waited < 2000) begin
            @(negedge logic_clk);
            waited++;
        end
        if (frames_seen < n) begin
            errors++;
            $display("Only %0d of %0d frames appeared on the line", frames_seen, n);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        int          total;
        void'($urandom(32'hbefc));   // One seed for the run
        logic_rst = 1'b1;
        data      = 8'h00;
        wb_adr    = 2'd0;
        wb_dat_w  = 32'd0;
        {data_valid, data_last, wb_cyc, wb_stb, wb_we} = 5'b00000;
        repeat (4) @(negedge logic_clk);
        logic_rst = 1'b0;
        // Reset values and then a new gap
        check_register(eth_tx_pkg::addr_ctrl, 32'd0);
        check_register(eth_tx_pkg::addr_gap, 32'd12);
        check_register(eth_tx_pkg::addr_frame_count, 32'd0);
        wishbone_cycle(1'b1, eth_tx_pkg::addr_gap, 32'(test_gap), rdata);
        check_register(eth_tx_pkg::addr_gap, 32'(test_gap));
        // Disabled framer leaves the source waiting
        data       = 8'hA5;
        data_valid = 1'b1;
        repeat (50) begin
            @(negedge logic_clk);
            if (data_ready || tx_valid) begin
                errors++;
                $display("Framer moved while tx_enable was clear");
            end
        end
        data_valid = 1'b0;
        wishbone_cycle(1'b1, eth_tx_pkg::addr_ctrl, 32'd1, rdata);
        send_frame(payload_lens[0]);   // Padded
        wait_for_frames(1);
        send_frame(payload_lens[1]);   // No padding
        wait_for_frames(2);
        for (int i = 2; i < 5; i++)
            send_frame(payload_lens[i]);
        wait_for_frames(5);
        check_register(eth_tx_pkg::addr_frame_count, 32'($size(payload_lens)));
        total = errors + eth_tx_top_i.assertions_i.assert_fails;
        $display("Errors: %0d from checks, %0d from assertions",
                 errors, eth_tx_top_i.assertions_i.assert_fails);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Line monitor sampled between rising edges
    initial begin
        int         count;
        int         low_cnt;
        int         exp_len;
        logic       prev_valid;
        logic [7:0] exp_byte;
        count      = 0;
        low_cnt    = 0;
        prev_valid = 1'b0;
        forever begin
            @(negedge logic_clk);
            if (tx_valid) begin
                // Gap length in gap plus at least one idle cycle
                if (!prev_valid && frames_seen > 0 && low_cnt < test_gap + 1) begin
                    errors++;
                    $display("Gap of %0d cycles before frame %0d is shorter than %0d",
                             low_cnt, frames_seen + 1, test_gap + 1);
                end
                if (expected_bytes.size() == 0) begin
                    errors++;
                    $display("Byte on the line while no frame was expected");
                end else begin
                    exp_byte = expected_bytes.pop_front();
                    if (tx_data !== exp_byte) begin
                        errors++;
                        $display("Error at %0t: tx_data expected %02h got %02h",
                                 $time, exp_byte, tx_data);
                    end
                end
                count++;
            end else begin
                if (prev_valid) begin   // Frame just ended
                    exp_len = (expected_lens.size() > 0) ? expected_lens.pop_front() : 0;
                    if (count != exp_len) begin
                        errors++;
                        $display("Frame %0d lasted %0d cycles instead of %0d",
                                 frames_seen + 1, count, exp_len);
                    end
                    frames_seen++;
                    count   = 0;
                    low_cnt = 0;
                end
                low_cnt++;
            end
            prev_valid = tx_valid;
        end
    end

    // Twice the frame, gap and slack cycles of all frames
    initial begin
        int limit;
        limit = 0;
        foreach (payload_lens[i])
            limit += eth_tx_pkg::preamble_len + eth_tx_pkg::fcs_len + test_gap + 10
                     + ((payload_lens[i] > eth_tx_pkg::min_frame_bytes)
                        ? payload_lens[i] : eth_tx_pkg::min_frame_bytes);
        #(2 * limit * 100);
        $display("Run did not finish within %0d cycles", 2 * limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== eth_tx.f ====
rtl/eth_tx_pkg.sv
rtl/eth_crc32.sv
rtl/eth_tx_framer.sv
rtl/eth_tx_csr.sv
rtl/eth_tx_top.sv
verification/eth_tx_clock_gen.sv
verification/eth_tx_assertions.sv
verification/eth_tx_tb.sv

// ==== Bender.yml ====
package:
  name: eth_tx

sources:
  # Design, package first
  - rtl/eth_tx_pkg.sv
  - rtl/eth_crc32.sv
  - rtl/eth_tx_framer.sv
  - rtl/eth_tx_csr.sv
  - rtl/eth_tx_top.sv
  # Testbench
  - target: simulation
    files:
      - verification/eth_tx_clock_gen.sv
      - verification/eth_tx_assertions.sv
      - verification/eth_tx_tb.sv
